// File: rtl/fth_defines.svh
// Widths and flush thresholds for the host ring writer, included by RTL and testbench alike
`ifndef FTH_DEFINES_SVH
`define FTH_DEFINES_SVH

// ==============================
// Data path geometry
// ==============================

// One message chunk from the source
`define FTH_CHUNK_W 128

// Chunks packed into one 512-bit cache line
`define FTH_CHUNKS_PER_LINE 4

// Ring buffer holds 2**FTH_RING_IDX_W lines
`define FTH_RING_IDX_W 6

// Host cache line address
`define FTH_ADDR_W 32

// ==============================
// Flush thresholds
// ==============================

// Idle counter, top bit set after about 16 idle cycles
`define FTH_IDLE_W 5

// Active-line counter, top bit set after 8 data lines
`define FTH_ACTIVE_W 4

`endif

// File: rtl/fth_pkg.sv
// Shared types for the host ring writer; modules refer to them as fth_pkg::name
`default_nettype none

`include "fth_defines.svh"

package fth_pkg;

    // ==============================
    // Data types
    // ==============================

    // Single chunk
    typedef logic [`FTH_CHUNK_W-1:0] chunk_t;

    // Cache line as a vector of chunks, slot 0 lowest
    typedef chunk_t [`FTH_CHUNKS_PER_LINE-1:0] line_t;

    // Slot of a chunk within a line
    typedef logic [$clog2(`FTH_CHUNKS_PER_LINE)-1:0] chunk_idx_t;

    // Line position within the ring
    typedef logic [`FTH_RING_IDX_W-1:0] ring_idx_t;

    // Host cache line address
    typedef logic [`FTH_ADDR_W-1:0] line_addr_t;

    // Sized to count every chunk the ring can hold
    typedef logic [2+`FTH_RING_IDX_W-1:0] chunk_count_t;

    // ==============================
    // Control types
    // ==============================

    // Memory write flavor
    typedef enum logic
    {
        WR_LINE,
        WR_FENCE
    } wr_kind_e;

    // Group state machine
    typedef enum logic [2:0]
    {
        NORMAL,
        ROTATE,
        EMIT_DATA,
        EMIT_HEADER,
        EMIT_FENCE
    } seq_state_e;

    // Write request toward host memory, held until granted
    typedef struct packed
    {
        logic       valid;
        wr_kind_e   kind;
        line_addr_t addr;
        line_t      data;
    } wr_req_t;

endpackage

`default_nettype wire

// File: rtl/fth_line_assembler.sv
// Line assembler: packs chunks into cache lines and tracks ring pointers for the write sequencer
`default_nettype none

`include "fth_defines.svh"

module fth_line_assembler
(
    input  logic                  clk,
    input  logic                  resetb,
    input  fth_pkg::chunk_t       tx_data,
    input  logic                  tx_enable,
    input  logic                  rotate_step,
    input  logic                  data_written,
    input  logic                  header_emit,
    input  logic                  group_done,
    input  fth_pkg::ring_idx_t    oldest_idx,
    output logic                  header_active,
    output logic                  line_full,
    output logic                  line_empty,
    output logic                  has_data,
    output logic                  ring_room_next,
    output fth_pkg::ring_idx_t    data_idx,
    output fth_pkg::ring_idx_t    header_idx,
    output fth_pkg::line_t        data_line,
    output fth_pkg::line_t        header_line,
    output fth_pkg::chunk_count_t num_chunks
);

    // Slot that the next chunk lands in
    fth_pkg::chunk_idx_t chunk_idx;
    fth_pkg::chunk_idx_t chunk_idx_next;
    fth_pkg::ring_idx_t  data_idx_next;

    // Current line with one more chunk shifted into the top slot
    fth_pkg::line_t      pushed_line;
    logic                shift_in;

    // ==============================
    // Line status
    // ==============================

    // Rotation pushes filler chunks, the host ignores those slots
    assign shift_in    = tx_enable || rotate_step;
    assign pushed_line = {tx_data, data_line[`FTH_CHUNKS_PER_LINE-1:1]};

    // Still filling the line that will become the header
    assign header_active = (header_idx == data_idx);
    assign line_full     = (chunk_idx == fth_pkg::chunk_idx_t'(`FTH_CHUNKS_PER_LINE-1));
    assign line_empty    = (chunk_idx == fth_pkg::chunk_idx_t'(0));

    // Header already full or holding at least one chunk
    assign has_data = !header_active || (chunk_idx != fth_pkg::chunk_idx_t'(1));

    // One line kept free so full and empty differ
    assign ring_room_next = ((data_idx_next + fth_pkg::ring_idx_t'(1)) != oldest_idx);

    // ==============================
    // Line buffers
    // ==============================

    always_ff @(posedge clk)
    begin
        if (shift_in)
        begin
            data_line <= pushed_line;
            // Header is kept aside since its count is only known at the end
            if (line_full && header_active)
            begin
                header_line <= pushed_line;
            end
        end
    end

    // ==============================
    // Pointers
    // ==============================

    always_comb
    begin
        chunk_idx_next = chunk_idx;
        data_idx_next  = data_idx;

        if (shift_in)
        begin
            if (!line_full)
            begin
                chunk_idx_next = chunk_idx + fth_pkg::chunk_idx_t'(1);
            end
            else
            begin
                chunk_idx_next = fth_pkg::chunk_idx_t'(0);
                // Header line is held in its own buffer, so move on at once
                if (header_active)
                begin
                    data_idx_next = data_idx + fth_pkg::ring_idx_t'(1);
                end
            end
        end
        else if (data_written)
        begin
            data_idx_next = data_idx + fth_pkg::ring_idx_t'(1);
        end
        else if (header_emit)
        begin
            // Slot 0 of the next header is reserved for the count
            chunk_idx_next = fth_pkg::chunk_idx_t'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            chunk_idx  <= fth_pkg::chunk_idx_t'(1);
            data_idx   <= '0;
            header_idx <= '0;
            num_chunks <= '0;
        end
        else
        begin
            chunk_idx <= chunk_idx_next;
            data_idx  <= data_idx_next;
            // Next group starts where data collection left off
            if (group_done)
            begin
                header_idx <= data_idx;
            end
            // Chunks per message
            if (tx_enable)
            begin
                num_chunks <= num_chunks + fth_pkg::chunk_count_t'(1);
            end
            else if (group_done)
            begin
                num_chunks <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/fth_flush_monitor.sv
// Flush monitor: raises the force-flush level after an idle run or a burst of written lines
`default_nettype none

`include "fth_defines.svh"

module fth_flush_monitor
(
    input  logic clk,
    input  logic resetb,
    input  logic tx_enable,
    input  logic in_normal,
    input  logic data_written,
    input  logic header_emit,
    input  logic has_data,
    output logic force_flush,
    output logic force_flush_next
);

    logic [`FTH_IDLE_W-1:0]   idle_cycles;
    logic [`FTH_IDLE_W-1:0]   idle_cycles_next;
    logic [`FTH_ACTIVE_W-1:0] active_lines;
    logic [`FTH_ACTIVE_W-1:0] active_lines_next;

    always_comb
    begin
        // Idle run counts only while waiting for chunks
        if (in_normal)
        begin
            idle_cycles_next = tx_enable ? '0 : idle_cycles + 1'b1;
        end
        else
        begin
            idle_cycles_next = '0;
        end

        // Granted data lines since the last header
        if (header_emit)
        begin
            active_lines_next = '0;
        end
        else if (data_written)
        begin
            active_lines_next = active_lines + 1'b1;
        end
        else
        begin
            active_lines_next = active_lines;
        end

        // Flush level is sticky until the header goes out
        if (header_emit)
        begin
            force_flush_next = 1'b0;
        end
        else if (has_data)
        begin
            force_flush_next = force_flush ||
                               idle_cycles_next[`FTH_IDLE_W-1] ||
                               active_lines_next[`FTH_ACTIVE_W-1];
        end
        else
        begin
            force_flush_next = force_flush;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            idle_cycles  <= '0;
            active_lines <= '0;
            force_flush  <= 1'b0;
        end
        else
        begin
            idle_cycles  <= idle_cycles_next;
            active_lines <= active_lines_next;
            force_flush  <= force_flush_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/fth_write_sequencer.sv
// Write sequencer: group state machine, tx_rdy and the host memory write request
`default_nettype none

module fth_write_sequencer
(
    input  logic                  clk,
    input  logic                  resetb,
    input  logic                  tx_enable,
    input  logic                  wr_grant,
    input  logic                  header_active,
    input  logic                  line_full,
    input  logic                  line_empty,
    input  logic                  ring_room_next,
    input  logic                  force_flush,
    input  logic                  force_flush_next,
    input  fth_pkg::ring_idx_t    data_idx,
    input  fth_pkg::ring_idx_t    header_idx,
    input  fth_pkg::line_addr_t   ring_base,
    input  fth_pkg::line_t        data_line,
    input  fth_pkg::line_t        header_line,
    input  fth_pkg::chunk_count_t num_chunks,
    output logic                  tx_rdy,
    output logic                  rotate_step,
    output logic                  data_written,
    output logic                  header_emit,
    output logic                  group_done,
    output logic                  in_normal,
    output fth_pkg::wr_req_t      wr_req
);

    fth_pkg::seq_state_e state;
    fth_pkg::seq_state_e state_next;

    // Header line with the chunk count dropped into slot 0
    fth_pkg::line_t      header_with_count;

    // ==============================
    // Group state machine
    // ==============================

    always_comb
    begin
        state_next = state;
        case (state)
            fth_pkg::NORMAL:
            begin
                if (!header_active && tx_enable && line_full)
                begin
                    // Data line complete
                    state_next = fth_pkg::EMIT_DATA;
                end
                else if (force_flush)
                begin
                    // Partial line must be rotated into place first
                    state_next = line_empty ? fth_pkg::EMIT_HEADER : fth_pkg::ROTATE;
                end
            end
            fth_pkg::ROTATE:
            begin
                if (line_full)
                begin
                    // Short message goes straight to the header
                    state_next = header_active ? fth_pkg::EMIT_HEADER : fth_pkg::EMIT_DATA;
                end
            end
            fth_pkg::EMIT_DATA:
            begin
                if (wr_grant)
                begin
                    state_next = force_flush ? fth_pkg::EMIT_HEADER : fth_pkg::NORMAL;
                end
            end
            fth_pkg::EMIT_HEADER:
            begin
                if (wr_grant)
                begin
                    state_next = fth_pkg::EMIT_FENCE;
                end
            end
            fth_pkg::EMIT_FENCE:
            begin
                if (wr_grant)
                begin
                    state_next = fth_pkg::NORMAL;
                end
            end
            default:
            begin
                state_next = fth_pkg::NORMAL;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state  <= fth_pkg::NORMAL;
            tx_rdy <= 1'b0;
        end
        else
        begin
            state  <= state_next;
            // Accept chunks only when idle, not flushing and the ring has room
            tx_rdy <= (state_next == fth_pkg::NORMAL) && !force_flush_next && ring_room_next;
        end
    end

    // Strobes and levels for the assembler and flush monitor
    assign in_normal    = (state == fth_pkg::NORMAL);
    assign rotate_step  = (state == fth_pkg::ROTATE);
    assign header_emit  = (state == fth_pkg::EMIT_HEADER);
    assign data_written = (state == fth_pkg::EMIT_DATA) && wr_grant;
    assign group_done   = (state == fth_pkg::EMIT_FENCE) && wr_grant;

    // ==============================
    // Memory write request
    // ==============================

    always_comb
    begin
        header_with_count    = header_line;
        header_with_count[0] = fth_pkg::chunk_t'(num_chunks);

        // Request level holds until wr_grant
        wr_req.valid = (state == fth_pkg::EMIT_DATA) ||
                       (state == fth_pkg::EMIT_HEADER) ||
                       (state == fth_pkg::EMIT_FENCE);

        case (state)
            fth_pkg::EMIT_DATA:
            begin
                wr_req.kind = fth_pkg::WR_LINE;
                wr_req.addr = ring_base + fth_pkg::line_addr_t'(data_idx);
                wr_req.data = data_line;
            end
            fth_pkg::EMIT_HEADER:
            begin
                wr_req.kind = fth_pkg::WR_LINE;
                wr_req.addr = ring_base + fth_pkg::line_addr_t'(header_idx);
                wr_req.data = header_with_count;
            end
            default:
            begin
                // Fence carries no meaningful address or payload
                wr_req.kind = fth_pkg::WR_FENCE;
                wr_req.addr = '0;
                wr_req.data = header_with_count;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/fifo_to_host.sv
// Top level of the host ring writer: chunk input in, cache line writes to host memory out
`default_nettype none

module fifo_to_host
(
    input  logic                clk,
    input  logic                resetb,
    input  fth_pkg::chunk_t     tx_data,
    input  logic                tx_enable,
    input  fth_pkg::line_addr_t ring_base,
    input  fth_pkg::ring_idx_t  oldest_idx,
    input  logic                wr_grant,
    output logic                tx_rdy,
    output fth_pkg::wr_req_t    wr_req,
    output fth_pkg::ring_idx_t  next_header_idx
);

    // ==============================
    // Assembler results
    // ==============================
    logic                  header_active;
    logic                  line_full;
    logic                  line_empty;
    logic                  has_data;
    logic                  ring_room_next;
    fth_pkg::ring_idx_t    data_idx;
    fth_pkg::ring_idx_t    header_idx;
    fth_pkg::line_t        data_line;
    fth_pkg::line_t        header_line;
    fth_pkg::chunk_count_t num_chunks;

    // ==============================
    // Sequencer and monitor controls
    // ==============================
    logic                  rotate_step;
    logic                  data_written;
    logic                  header_emit;
    logic                  group_done;
    logic                  in_normal;
    logic                  force_flush;
    logic                  force_flush_next;

    // Host polls this to find the next message header
    assign next_header_idx = header_idx;

    fth_line_assembler u_assembler
    (
        .clk            (clk),
        .resetb         (resetb),
        .tx_data        (tx_data),
        .tx_enable      (tx_enable),
        .rotate_step    (rotate_step),
        .data_written   (data_written),
        .header_emit    (header_emit),
        .group_done     (group_done),
        .oldest_idx     (oldest_idx),
        .header_active  (header_active),
        .line_full      (line_full),
        .line_empty     (line_empty),
        .has_data       (has_data),
        .ring_room_next (ring_room_next),
        .data_idx       (data_idx),
        .header_idx     (header_idx),
        .data_line      (data_line),
        .header_line    (header_line),
        .num_chunks     (num_chunks)
    );

    fth_flush_monitor u_flush_monitor
    (
        .clk              (clk),
        .resetb           (resetb),
        .tx_enable        (tx_enable),
        .in_normal        (in_normal),
        .data_written     (data_written),
        .header_emit      (header_emit),
        .has_data         (has_data),
        .force_flush      (force_flush),
        .force_flush_next (force_flush_next)
    );

    fth_write_sequencer u_sequencer
    (
        .clk              (clk),
        .resetb           (resetb),
        .tx_enable        (tx_enable),
        .wr_grant         (wr_grant),
        .header_active    (header_active),
        .line_full        (line_full),
        .line_empty       (line_empty),
        .ring_room_next   (ring_room_next),
        .force_flush      (force_flush),
        .force_flush_next (force_flush_next),
        .data_idx         (data_idx),
        .header_idx       (header_idx),
        .ring_base        (ring_base),
        .data_line        (data_line),
        .header_line      (header_line),
        .num_chunks       (num_chunks),
        .tx_rdy           (tx_rdy),
        .rotate_step      (rotate_step),
        .data_written     (data_written),
        .header_emit      (header_emit),
        .group_done       (group_done),
        .in_normal        (in_normal),
        .wr_req           (wr_req)
    );

endmodule

`default_nettype wire

// File: testbench/tb_fifo_to_host.sv
// Testbench for the host ring writer: drives chunks, models host memory and checks writes
`default_nettype none

`include "fth_defines.svh"

module tb_fifo_to_host;

    localparam int          CLK_PERIOD      = 10;
    localparam int          SLOTS           = `FTH_CHUNKS_PER_LINE;
    localparam int          TOTAL_CHUNKS    = 3 + 11 + 9 + 35 + 7;
    localparam int          WATCHDOG_CYCLES = 200 * TOTAL_CHUNKS + 2000;
    localparam int          WAIT_LIMIT      = 1000;
    localparam logic [31:0] RING_BASE       = 32'h0001_0000;

    logic                  clk;
    logic                  resetb;
    fth_pkg::chunk_t       tx_data;
    logic                  tx_enable;
    fth_pkg::line_addr_t   ring_base;
    fth_pkg::ring_idx_t    oldest_idx;
    logic                  wr_grant;
    logic                  tx_rdy;
    fth_pkg::wr_req_t      wr_req;
    fth_pkg::ring_idx_t    next_header_idx;

    // Host memory model and bookkeeping
    fth_pkg::wr_req_t      wr_log[$];
    int unsigned           wr_cycle[$];
    fth_pkg::chunk_t       sent[$];
    int unsigned           cycle;
    logic                  hold_grant;
    int unsigned           grant_wait;
    int                    errors;
    int                    tests_run;
    int                    tests_passed;

    fifo_to_host DUT
    (
        .clk             (clk),
        .resetb          (resetb),
        .tx_data         (tx_data),
        .tx_enable       (tx_enable),
        .ring_base       (ring_base),
        .oldest_idx      (oldest_idx),
        .wr_grant        (wr_grant),
        .tx_rdy          (tx_rdy),
        .wr_req          (wr_req),
        .next_header_idx (next_header_idx)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==============================
    // Host side models
    // ==============================

    // Grant pulse after a random delay, held off while hold_grant is set
    always @(negedge clk)
    begin
        if (wr_grant)
        begin
            wr_grant <= 1'b0;
        end
        else if (wr_req.valid && !hold_grant)
        begin
            if (grant_wait == 0)
            begin
                wr_grant   <= 1'b1;
                grant_wait <= $urandom_range(3, 0);
            end
            else
            begin
                grant_wait <= grant_wait - 1;
            end
        end
    end

    // Granted writes land in the log
    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (resetb && wr_req.valid && wr_grant)
        begin
            wr_log.push_back(wr_req);
            wr_cycle.push_back(cycle);
        end
    end

    // ==============================
    // Protocol assertions
    // ==============================

    a_reset_quiet: assert property (@(posedge clk) !resetb |=> (!wr_req.valid && !tx_rdy))
    else
    begin
        errors++;
        $display("Error at %0t: request or tx_rdy high right after reset", $time);
    end

    a_request_held: assert property (@(posedge clk) disable iff (!resetb)
        (wr_req.valid && !wr_grant) |=> (wr_req.valid && $stable(wr_req)))
    else
    begin
        errors++;
        $display("Error at %0t: write request changed while waiting for grant", $time);
    end

    a_busy_not_ready: assert property (@(posedge clk) disable iff (!resetb)
        wr_req.valid |-> !tx_rdy)
    else
    begin
        errors++;
        $display("Error at %0t: tx_rdy high while a write is pending", $time);
    end

    // ==============================
    // Helpers
    // ==============================

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, got);
        end
    endtask

    task automatic note_failure(input string text);
        errors++;
        $display("Error at %0t: %s", $time, text);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before)
        begin
            tests_passed++;
            $display("Test %s: ok", name);
        end
        else
        begin
            $display("Test %s: %0d error(s)", name, errors - errs_before);
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (tx_rdy !== 1'b1 && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT)
        begin
            note_failure("tx_rdy never rose");
        end
    endtask

    task automatic send_chunk(input fth_pkg::chunk_t d);
        wait_ready();
        tx_data   = d;
        tx_enable = 1'b1;
        @(negedge clk);
        tx_enable = 1'b0;
    endtask

    // Sends n random chunks and keeps them for comparison
    task automatic send_message(input int n);
        fth_pkg::chunk_t c;
        sent.delete();
        for (int i = 0; i < n; i++)
        begin
            c = {$urandom, $urandom, $urandom, $urandom};
            sent.push_back(c);
            send_chunk(c);
        end
    endtask

    task automatic wait_group_end(input int start);
        int n;
        n = 0;
        while (n < WAIT_LIMIT && !(wr_log.size() > start &&
               wr_log[wr_log.size() - 1].kind == fth_pkg::WR_FENCE))
        begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT)
        begin
            note_failure("group never ended with a fence");
        end
    endtask

    // Data lines at h+1.., then header at h with the count, then a fence
    task automatic check_group(input fth_pkg::ring_idx_t h, input int start, input int n,
                               input bit burst);
        int               nd;
        fth_pkg::wr_req_t w;
        nd = n / SLOTS;
        if (wr_log.size() != start + nd + 2)
        begin
            note_failure($sformatf("expected %0d writes, saw %0d", nd + 2, wr_log.size() - start));
        end
        else
        begin
            for (int k = 0; k < nd; k++)
            begin
                w = wr_log[start + k];
                check_value("data kind", 128'(w.kind), 128'(fth_pkg::WR_LINE));
                check_value("data addr", 128'(w.addr),
                            128'(RING_BASE + 32'(fth_pkg::ring_idx_t'(h + 1 + k))));
                for (int j = 0; j < SLOTS; j++)
                begin
                    if ((SLOTS - 1) + SLOTS * k + j < n)
                    begin
                        check_value($sformatf("line %0d slot %0d", k, j), w.data[j],
                                    sent[(SLOTS - 1) + SLOTS * k + j]);
                    end
                end
            end
            w = wr_log[start + nd];
            check_value("header kind", 128'(w.kind), 128'(fth_pkg::WR_LINE));
            check_value("header addr", 128'(w.addr), 128'(RING_BASE + 32'(h)));
            check_value("header count", w.data[0], 128'(n));
            for (int j = 1; j < SLOTS; j++)
            begin
                check_value($sformatf("header slot %0d", j), w.data[j], sent[j - 1]);
            end
            check_value("fence addr", 128'(wr_log[start + nd + 1].addr), 128'(0));
            // Line-count flush leaves no idle gap before the header
            if (burst && wr_cycle[start + nd] - wr_cycle[start + nd - 1] > 10)
            begin
                note_failure("header came late after the eighth data line");
            end
        end
        repeat (2) @(negedge clk);
        check_value("next_header_idx", 128'(next_header_idx),
                    128'(fth_pkg::ring_idx_t'(h + 1 + nd)));
    endtask

    task automatic run_message(input string name, input int n, input bit burst);
        int                 errs_before;
        int                 start;
        fth_pkg::ring_idx_t h;
        errs_before = errors;
        h           = next_header_idx;
        start       = wr_log.size();
        send_message(n);
        wait_group_end(start);
        check_group(h, start, n, burst);
        report_test(name, errs_before);
    endtask

    task automatic run_back_pressure();
        int                 errs_before;
        int                 start;
        int                 n;
        fth_pkg::ring_idx_t h;
        errs_before = errors;
        h           = next_header_idx;
        start       = wr_log.size();
        hold_grant  = 1'b1;
        send_message(7);
        n = 0;
        while (!wr_req.valid && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        repeat (30)
        begin
            @(negedge clk);
            check_value("tx_rdy", 128'(tx_rdy), 128'(0));
            check_value("wr_req.valid", 128'(wr_req.valid), 128'(1));
            // Group cannot close while its data line waits
            check_value("next_header_idx", 128'(next_header_idx), 128'(h));
        end
        hold_grant = 1'b0;
        wait_group_end(start);
        check_group(h, start, 7, 1'b0);
        report_test("back_pressure", errs_before);
    endtask

    // Room test uses next data index plus one against oldest_idx
    task automatic run_ring_full();
        int                 errs_before;
        fth_pkg::ring_idx_t h;
        errs_before = errors;
        h           = next_header_idx;
        oldest_idx  = fth_pkg::ring_idx_t'(h + 1);
        repeat (3) @(negedge clk);
        repeat (20)
        begin
            @(negedge clk);
            check_value("tx_rdy", 128'(tx_rdy), 128'(0));
        end
        oldest_idx = fth_pkg::ring_idx_t'(h + 2);
        wait_ready();
        report_test("ring_full", errs_before);
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial
    begin
        int errs_before;
        void'($urandom(37414));
        resetb       = 1'b0;
        tx_data      = '0;
        tx_enable    = 1'b0;
        ring_base    = RING_BASE;
        oldest_idx   = '0;
        wr_grant     <= 1'b0;
        hold_grant   = 1'b0;
        grant_wait   <= 0;
        cycle        <= 0;
        errors       = 0;
        tests_run    = 0;
        tests_passed = 0;

        repeat (2) @(negedge clk);
        resetb      = 1'b1;
        errs_before = errors;
        @(negedge clk);
        check_value("tx_rdy", 128'(tx_rdy), 128'(1));
        check_value("wr_req.valid", 128'(wr_req.valid), 128'(0));
        report_test("reset", errs_before);

        run_message("short_message", 3, 1'b0);
        run_message("long_message", 11, 1'b0);
        // Two chunks left over, so the last data line is rotated into place
        run_message("rotated_message", 9, 1'b0);
        run_message("line_count_flush", 35, 1'b1);
        run_back_pressure();
        run_ring_full();

        $display("Tests run: %0d, passed: %0d, errors: %0d", tests_run, tests_passed, errors);
        if (errors == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog sized from the chunk count of all tests
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+rtl
rtl/fth_pkg.sv
rtl/fth_line_assembler.sv
rtl/fth_flush_monitor.sv
rtl/fth_write_sequencer.sv
rtl/fifo_to_host.sv
testbench/tb_fifo_to_host.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fifo_to_host
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
